/* bench/fetch_chk.sv */
`timescale 1ns/10ps

module fetch_chk (
    input logic                   clk,
    input logic                   reseted,
    input logic                   mem_req,
    input logic                   mem_valid,
    input logic                   f2e_exc_start,
    input logic                   dbg_mode,
    input fetch_pkg::cache_cmd_t  c_cmd,
    input fetch_pkg::cache_resp_t c_response
);

    // Refill request is held until memory answers
    req_held: assert property (@(posedge clk) disable iff (reseted)
        (mem_req && !mem_valid) |=> mem_req)
        else $error("mem_req dropped before mem_valid");

    // Cache only answers done to a command
    done_after_cmd: assert property (@(posedge clk) disable iff (reseted)
        (c_cmd == fetch_pkg::CACHE_CMD_NONE) |=> (c_response != fetch_pkg::CACHE_RESP_DONE))
        else $error("c_response done without a command");

    no_exc_in_debug: assert property (@(posedge clk) disable iff (reseted)
        !(f2e_exc_start && dbg_mode))
        else $error("f2e_exc_start raised in debug mode");

endmodule

bind fetch_top fetch_chk i_fetch_chk (
    .clk           (clk),
    .reseted       (reseted),
    .mem_req       (mem_req),
    .mem_valid     (mem_valid),
    .f2e_exc_start (f2e_exc_start),
    .dbg_mode      (dbg_mode),
    .c_cmd         (c_cmd),
    .c_response    (c_response)
);

/* bench/fetch_tb.sv */
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_tb;

    localparam int          WAIT_LIMIT = 64;
    localparam logic [31:0] MTVEC      = 32'h0000_0100;

    // One row per fetch boundary with the expected word and the execute response
    typedef struct packed {
        logic [2:0]          test;
        logic                fault;
        logic [31:0]         pc;
        logic                miss;
        logic [3:0]          idle;
        fetch_pkg::e2f_cmd_t cmd;
        logic [31:0]         addr;
        logic [1:0]          irq;
        logic [1:0]          irq_en;
        logic                dbg;
        logic                exc;
        logic [31:0]         cause;
    } row_t;

    logic                clk;
    logic                reseted;
    logic [31:0]         csr_mtvec;
    logic                dbg_request;
    logic                dbg_set_pc;
    logic                dbg_exit_request;
    logic [31:0]         dbg_pc;
    logic                dbg_mode;
    logic                dbg_done;
    logic                irq_timer_en;
    logic                irq_exti_en;
    logic                irq_timer;
    logic                irq_exti;
    logic                e2f_ready;
    fetch_pkg::e2f_cmd_t e2f_cmd;
    logic [31:0]         e2f_exc_epc;
    logic [31:0]         e2f_branchtarget;
    logic [31:0]         f2e_instr;
    logic [31:0]         f2e_pc;
    logic                f2e_exc_start;
    fetch_pkg::cause_t   f2e_cause;
    logic                mem_req;
    logic [31:0]         mem_addr;
    logic                mem_valid = 1'b0;
    logic [31:0]         mem_data = 32'h0;
    logic                mem_error = 1'b0;

    row_t  table_q[$];
    int    checks = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    refills = 0;
    int    last_refills = 0;
    int    mem_count = 0;
    logic  mem_busy = 1'b0;
    logic  [31:0] mem_seen = 32'h0;
    logic  timed_out = 1'b0;
    string test_names[7] = '{"", "reset and sequential fetch", "stall, branch and mret",
                             "cache flush", "interrupts", "fetch faults", "debug mode"};

    fetch_top i_fetch_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Memory content derived from the whole word address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    // Refill port with random latency and errors for 0x3000 to 0x30ff
    always @(negedge clk) begin
        mem_valid = 1'b0;
        mem_error = 1'b0;
        if (reseted) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            mem_count--;
            if (mem_count == 0) begin
                mem_valid = 1'b1;
                mem_data  = mem_word(mem_addr);
                mem_error = (mem_addr[31:8] == 24'h00_0030);
                mem_busy  = 1'b0;
            end
        end else if (mem_req) begin
            mem_busy  = 1'b1;
            mem_count = int'($urandom % 4) + 1;
            mem_seen  = mem_addr;
            refills++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic add_row(input logic [2:0] test, input logic fault, input logic [31:0] pc,
                           input logic miss, input logic [3:0] idle,
                           input fetch_pkg::e2f_cmd_t cmd, input logic [31:0] addr,
                           input logic [1:0] irq, input logic [1:0] irq_en, input logic dbg,
                           input logic exc, input logic [31:0] cause);
        row_t r;
        r = '{test, fault, pc, miss, idle, cmd, addr, irq, irq_en, dbg, exc, cause};
        table_q.push_back(r);
    endtask

    task automatic set_defaults();
        e2f_cmd          = fetch_pkg::E2F_CMD_NONE;
        irq_timer        = 1'b0;
        irq_exti         = 1'b0;
        irq_timer_en     = 1'b0;
        irq_exti_en      = 1'b0;
        dbg_request      = 1'b0;
        dbg_set_pc       = 1'b0;
        dbg_exit_request = 1'b0;
    endtask

    function automatic logic at_boundary(input logic fault);
        if (fault) begin
            return (i_fetch_top.c_response == fetch_pkg::CACHE_RESP_MISSALIGNED) ||
                   (i_fetch_top.c_response == fetch_pkg::CACHE_RESP_ACCESSFAULT);
        end
        return (i_fetch_top.c_response == fetch_pkg::CACHE_RESP_DONE) &&
               !i_fetch_top.flushing && !dbg_mode;
    endfunction

    task automatic wait_boundary(input logic fault);
        int count;
        count = 0;
        while (!at_boundary(fault)) begin
            @(negedge clk);
            count++;
            if (count > WAIT_LIMIT) begin
                $display("Timeout at %0t ns: no fetch result arrived", $time);
                timed_out = 1'b1;
                return;
            end
        end
    endtask

    task automatic run_debug(input logic [31:0] addr);
        int count;
        count = 0;
        do begin
            @(negedge clk);
            count++;
            if (count > WAIT_LIMIT) begin
                $display("Timeout at %0t ns: debug mode was never entered", $time);
                timed_out = 1'b1;
                return;
            end
        end while (!dbg_mode);
        dbg_request = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_value("f2e_instr", f2e_instr, `INSTR_NOP);
            check_value("dbg_done", dbg_done, 1'b0);
        end
        dbg_pc     = addr;
        dbg_set_pc = 1'b1;
        #1;
        check_value("dbg_done", dbg_done, 1'b1);
        @(negedge clk);
        dbg_set_pc       = 1'b0;
        dbg_exit_request = 1'b1;
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] hold_pc;
        logic [31:0] hold_instr;
        wait_boundary(r.fault);
        if (timed_out) begin
            return;
        end
        check_value("f2e_pc", f2e_pc, r.pc);
        check_value("f2e_instr", f2e_instr, r.fault ? `INSTR_NOP : mem_word(r.pc));
        check_value("mem_req", refills != last_refills, r.miss);
        if (r.miss) begin
            check_value("mem_addr", mem_seen, r.pc);
        end
        last_refills = refills;
        hold_pc      = f2e_pc;
        hold_instr   = f2e_instr;
        // Execute stalls and the word is replayed
        e2f_ready = (r.idle == 0);
        for (int k = 0; k < r.idle; k++) begin
            @(negedge clk);
            check_value("f2e_pc", f2e_pc, hold_pc);
            check_value("f2e_instr", f2e_instr, hold_instr);
        end
        e2f_ready        = 1'b1;
        e2f_cmd          = r.cmd;
        e2f_branchtarget = r.addr;
        e2f_exc_epc      = r.addr;
        irq_exti         = r.irq[1];
        irq_timer        = r.irq[0];
        irq_exti_en      = r.irq_en[1];
        irq_timer_en     = r.irq_en[0];
        dbg_request      = r.dbg;
        #1;
        check_value("f2e_exc_start", f2e_exc_start, r.exc);
        if (r.exc) begin
            check_value("f2e_cause", f2e_cause, r.cause);
        end
        if (r.dbg) begin
            run_debug(r.addr);
        end
        @(negedge clk);
        set_defaults();
    endtask

    task automatic report_test(input int test);
        $display("Test %0d (%s): %s", test, test_names[test],
                 (test_errors == 0) ? "ok" : "errors found");
        test_errors = 0;
    endtask

    initial begin
        int cur_test;
        void'($urandom(32'hb207_666c));
        reseted     = 1'b1;
        csr_mtvec   = MTVEC;
        dbg_pc      = 32'h0;
        e2f_ready   = 1'b1;
        e2f_exc_epc = 32'h0;
        e2f_branchtarget = 32'h0;
        set_defaults();

        add_row(1, 0, 32'h2000, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h2004, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h2008, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h200c, 1, 0, fetch_pkg::E2F_CMD_BRANCH, 32'h2000, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h2000, 0, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h2004, 0, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(1, 0, 32'h2008, 0, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(2, 0, 32'h200c, 0, 4, fetch_pkg::E2F_CMD_BRANCH, 32'h2010, 0, 0, 0, 0, 0);
        add_row(2, 0, 32'h2010, 1, 3, fetch_pkg::E2F_CMD_EXC_RETURN, 32'h2004, 0, 0, 0, 0, 0);
        add_row(2, 0, 32'h2004, 0, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(3, 0, 32'h2008, 0, 0, fetch_pkg::E2F_CMD_FLUSH,  0, 0, 0, 0, 0, 0);
        add_row(3, 0, 32'h200c, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(3, 0, 32'h2010, 1, 0, fetch_pkg::E2F_CMD_BRANCH, 32'h2000, 0, 0, 0, 0, 0);
        add_row(3, 0, 32'h2000, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(4, 0, 32'h2004, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 2'b01, 2'b01, 0, 1,
                fetch_pkg::CAUSE_TIMER_INTERRUPT);
        add_row(4, 0, MTVEC,    1, 0, fetch_pkg::E2F_CMD_NONE,   0, 2'b10, 2'b00, 0, 0, 0);
        add_row(4, 0, 32'h0104, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 2'b10, 2'b10, 0, 1,
                fetch_pkg::CAUSE_EXTERNAL_INTERRUPT);
        add_row(4, 0, MTVEC,    0, 0, fetch_pkg::E2F_CMD_BRANCH, 32'h3000, 0, 0, 0, 0, 0);
        add_row(5, 1, 32'h3000, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 1,
                fetch_pkg::CAUSE_INSTR_ACCESS_FAULT);
        add_row(5, 0, MTVEC,    0, 0, fetch_pkg::E2F_CMD_BRANCH, 32'h2006, 0, 0, 0, 0, 0);
        add_row(5, 1, 32'h2006, 0, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 1,
                fetch_pkg::CAUSE_INSTR_MISALIGNED);
        add_row(6, 0, MTVEC,    0, 0, fetch_pkg::E2F_CMD_NONE,   32'h2018, 0, 0, 1, 0, 0);
        add_row(6, 0, 32'h2018, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);
        add_row(6, 0, 32'h201c, 1, 0, fetch_pkg::E2F_CMD_NONE,   0, 0, 0, 0, 0, 0);

        repeat (5) @(negedge clk);
        reseted  = 1'b0;
        // Outputs still hold their reset state
        check_value("mem_req", mem_req, 1'b0);
        check_value("f2e_exc_start", f2e_exc_start, 1'b0);
        check_value("dbg_mode", dbg_mode, 1'b0);
        check_value("dbg_done", dbg_done, 1'b0);
        check_value("f2e_instr", f2e_instr, `INSTR_NOP);
        cur_test = table_q[0].test;
        foreach (table_q[i]) begin
            if (table_q[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = table_q[i].test;
            end
            apply_row(table_q[i]);
            if (timed_out) begin
                break;
            end
        end
        if (!timed_out) begin
            report_test(cur_test);
        end
        $display("Checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* common/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First fetch address after reset
`define FETCH_RESET_VECTOR 32'h0000_2000

// Direct-mapped cache size, one word per line
`define ICACHE_LINES 8

// addi x0, x0, 0
`define INSTR_NOP 32'h0000_0013

`endif

/* common/fetch_pkg.sv */
package fetch_pkg;

    // Commands from the fetch controller to the instruction cache
    typedef enum logic [1:0] {
        CACHE_CMD_NONE      = 2'd0,
        CACHE_CMD_EXECUTE   = 2'd1,
        CACHE_CMD_FLUSH_ALL = 2'd2
    } cache_cmd_t;

    // Cache answer, valid one cycle after the command
    typedef enum logic [2:0] {
        CACHE_RESP_IDLE        = 3'd0,
        CACHE_RESP_WAIT        = 3'd1,
        CACHE_RESP_DONE        = 3'd2,
        CACHE_RESP_MISSALIGNED = 3'd3,
        CACHE_RESP_ACCESSFAULT = 3'd4
    } cache_resp_t;

    // Execute to fetch command, only meaningful with e2f_ready
    typedef enum logic [2:0] {
        E2F_CMD_NONE       = 3'd0,
        E2F_CMD_BRANCH     = 3'd1,
        E2F_CMD_FLUSH      = 3'd2,
        E2F_CMD_EXC_START  = 3'd3,
        E2F_CMD_EXC_RETURN = 3'd4
    } e2f_cmd_t;

    // Machine mode mcause values
    typedef enum logic [31:0] {
        CAUSE_INSTR_MISALIGNED   = 32'h0000_0000,
        CAUSE_INSTR_ACCESS_FAULT = 32'h0000_0001,
        CAUSE_TIMER_INTERRUPT    = 32'h8000_0007,
        CAUSE_EXTERNAL_INTERRUPT = 32'h8000_000b
    } cause_t;

endpackage

/* fetch/fetch_ctrl.sv */
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_ctrl (
    input  logic                   clk,
    input  logic                   reseted,
    input  logic [31:0]            csr_mtvec,
    input  logic                   dbg_request,
    input  logic                   dbg_set_pc,
    input  logic                   dbg_exit_request,
    input  logic [31:0]            dbg_pc,
    input  logic                   irq_timer_en,
    input  logic                   irq_exti_en,
    input  logic                   irq_timer,
    input  logic                   irq_exti,
    input  logic                   e2f_ready,
    input  fetch_pkg::e2f_cmd_t    e2f_cmd,
    input  logic [31:0]            e2f_exc_epc,
    input  logic [31:0]            e2f_branchtarget,
    input  fetch_pkg::cache_resp_t c_response,
    input  logic                   c_reset_done,
    output fetch_pkg::cache_cmd_t  c_cmd,
    output logic [31:0]            c_address,
    output logic [31:0]            pc,
    output logic                   flushing,
    output logic                   bubble,
    output logic                   dbg_mode,
    output logic                   dbg_done,
    output logic                   f2e_exc_start,
    output logic                   irq_taken_exti,
    output logic                   irq_taken_timer
);

    logic [31:0] pc_nxt;
    logic        after_reset;
    logic        after_reset_nxt;
    logic        flushing_nxt;
    logic        bubble_nxt;
    logic        dbg_mode_nxt;
    logic        cache_done;
    logic        cache_idle;
    logic        cache_wait;
    logic        cache_error;
    logic        exti_hit;
    logic        timer_hit;
    logic        fetch_boundary;

    assign cache_done  = (c_response == fetch_pkg::CACHE_RESP_DONE);
    assign cache_idle  = (c_response == fetch_pkg::CACHE_RESP_IDLE);
    assign cache_wait  = (c_response == fetch_pkg::CACHE_RESP_WAIT);
    assign cache_error = (c_response == fetch_pkg::CACHE_RESP_MISSALIGNED) ||
                         (c_response == fetch_pkg::CACHE_RESP_ACCESSFAULT);

    assign exti_hit  = irq_exti_en && irq_exti;
    assign timer_hit = irq_timer_en && irq_timer;

    // A fault always ends the current fetch, execute or not
    assign fetch_boundary = after_reset || cache_error ||
                            (e2f_ready && (cache_done || cache_idle));

    // Cache sees the address of the fetch being started
    assign c_address = pc_nxt;

    always_comb begin
        pc_nxt          = pc;
        c_cmd           = fetch_pkg::CACHE_CMD_NONE;
        after_reset_nxt = after_reset;
        flushing_nxt    = flushing;
        bubble_nxt      = bubble;
        dbg_mode_nxt    = dbg_mode;
        f2e_exc_start   = 1'b0;
        dbg_done        = 1'b0;
        irq_taken_exti  = 1'b0;
        irq_taken_timer = 1'b0;
        // Fresh data ends the bubble
        if (cache_done && !flushing) begin
            bubble_nxt = 1'b0;
        end
        if (c_reset_done) begin
            if (dbg_mode) begin
                if (dbg_exit_request) begin
                    c_cmd        = fetch_pkg::CACHE_CMD_EXECUTE;
                    dbg_mode_nxt = 1'b0;
                    bubble_nxt   = 1'b1;
                end else if (dbg_set_pc) begin
                    pc_nxt   = dbg_pc;
                    dbg_done = 1'b1;
                end
            end else if (flushing) begin
                // Flush acknowledged, continue after the flush instruction
                if (cache_done) begin
                    c_cmd        = fetch_pkg::CACHE_CMD_EXECUTE;
                    pc_nxt       = pc + 32'd4;
                    flushing_nxt = 1'b0;
                    bubble_nxt   = 1'b1;
                end
            end else if (cache_wait) begin
                // Miss in progress, repeat the same address
                c_cmd = fetch_pkg::CACHE_CMD_EXECUTE;
            end else if (fetch_boundary) begin
                c_cmd = fetch_pkg::CACHE_CMD_EXECUTE;
                if (after_reset) begin
                    pc_nxt          = `FETCH_RESET_VECTOR;
                    after_reset_nxt = 1'b0;
                    bubble_nxt      = 1'b1;
                end else if (dbg_request) begin
                    c_cmd        = fetch_pkg::CACHE_CMD_NONE;
                    dbg_mode_nxt = 1'b1;
                    bubble_nxt   = 1'b1;
                end else if (exti_hit || timer_hit) begin
                    pc_nxt          = csr_mtvec;
                    f2e_exc_start   = 1'b1;
                    irq_taken_exti  = exti_hit;
                    irq_taken_timer = !exti_hit;
                    bubble_nxt      = 1'b1;
                end else if (e2f_ready && e2f_cmd == fetch_pkg::E2F_CMD_EXC_RETURN) begin
                    pc_nxt     = e2f_exc_epc;
                    bubble_nxt = 1'b1;
                end else if (e2f_ready && e2f_cmd == fetch_pkg::E2F_CMD_BRANCH) begin
                    pc_nxt     = e2f_branchtarget;
                    bubble_nxt = 1'b1;
                end else if (e2f_ready && e2f_cmd == fetch_pkg::E2F_CMD_FLUSH) begin
                    c_cmd        = fetch_pkg::CACHE_CMD_FLUSH_ALL;
                    flushing_nxt = 1'b1;
                    bubble_nxt   = 1'b1;
                end else if (e2f_ready && e2f_cmd == fetch_pkg::E2F_CMD_EXC_START) begin
                    pc_nxt     = csr_mtvec;
                    bubble_nxt = 1'b1;
                end else if (cache_error) begin
                    pc_nxt        = csr_mtvec;
                    f2e_exc_start = 1'b1;
                    bubble_nxt    = 1'b1;
                end else begin
                    pc_nxt = pc + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            pc          <= `FETCH_RESET_VECTOR;
            after_reset <= 1'b1;
            flushing    <= 1'b0;
            bubble      <= 1'b1;
            dbg_mode    <= 1'b0;
        end else begin
            pc          <= pc_nxt;
            after_reset <= after_reset_nxt;
            flushing    <= flushing_nxt;
            bubble      <= bubble_nxt;
            dbg_mode    <= dbg_mode_nxt;
        end
    end

endmodule

/* fetch/fetch_issue.sv */
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_issue (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::cache_resp_t c_response,
    input  logic [31:0]            c_load_data,
    input  logic                   c_reset_done,
    input  logic [31:0]            pc,
    input  logic                   flushing,
    input  logic                   bubble,
    input  logic                   dbg_mode,
    input  logic                   irq_taken_exti,
    input  logic                   irq_taken_timer,
    output logic [31:0]            f2e_instr,
    output logic [31:0]            f2e_pc,
    output fetch_pkg::cause_t      f2e_cause
);

    // Last word handed to execute, replayed while the cache is idle
    logic [31:0] held_word;

    assign f2e_pc = pc;

    always_comb begin
        f2e_instr = `INSTR_NOP;
        if (c_reset_done && !dbg_mode) begin
            if (c_response == fetch_pkg::CACHE_RESP_DONE) begin
                if (!flushing) begin
                    f2e_instr = c_load_data;
                end
            end else if (c_response == fetch_pkg::CACHE_RESP_IDLE) begin
                if (!bubble) begin
                    f2e_instr = held_word;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            held_word <= `INSTR_NOP;
        end else begin
            held_word <= f2e_instr;
        end
    end

    // Fetch faults first, then interrupts
    always_comb begin
        f2e_cause = fetch_pkg::CAUSE_INSTR_MISALIGNED;
        if (c_response == fetch_pkg::CACHE_RESP_MISSALIGNED) begin
            f2e_cause = fetch_pkg::CAUSE_INSTR_MISALIGNED;
        end else if (c_response == fetch_pkg::CACHE_RESP_ACCESSFAULT) begin
            f2e_cause = fetch_pkg::CAUSE_INSTR_ACCESS_FAULT;
        end else if (irq_taken_exti) begin
            f2e_cause = fetch_pkg::CAUSE_EXTERNAL_INTERRUPT;
        end else if (irq_taken_timer) begin
            f2e_cause = fetch_pkg::CAUSE_TIMER_INTERRUPT;
        end
    end

endmodule

/* icache/icache.sv */
`timescale 1ns/10ps

`include "fetch_config.svh"

module icache (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::cache_cmd_t  c_cmd,
    input  logic [31:0]            c_address,
    input  logic                   mem_valid,
    input  logic [31:0]            mem_data,
    input  logic                   mem_error,
    output fetch_pkg::cache_resp_t c_response,
    output logic [31:0]            c_load_data,
    output logic                   c_reset_done,
    output logic                   mem_req,
    output logic [31:0]            mem_addr
);

    localparam int LINES = `ICACHE_LINES;
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 30 - IDX_W;

    localparam logic [1:0] ST_INIT   = 2'd0;
    localparam logic [1:0] ST_READY  = 2'd1;
    localparam logic [1:0] ST_REFILL = 2'd2;

    logic [1:0]             state;
    logic [IDX_W-1:0]       init_idx;
    logic                   refill_err;
    fetch_pkg::cache_cmd_t  req_cmd;
    logic [31:0]            req_addr;
    logic [LINES-1:0]       valid;
    logic [TAG_W-1:0]       tag_mem  [LINES];
    logic [31:0]            data_mem [LINES];
    logic [IDX_W-1:0]       req_idx;
    logic [IDX_W-1:0]       mem_idx;
    logic                   hit;
    logic                   start_refill;
    logic                   refill_write;

    assign req_idx = req_addr[IDX_W+1:2];
    assign mem_idx = mem_addr[IDX_W+1:2];
    assign hit     = valid[req_idx] && (tag_mem[req_idx] == req_addr[31:IDX_W+2]);

    assign c_reset_done = (state != ST_INIT);
    assign c_load_data  = data_mem[req_idx];
    assign start_refill = (state == ST_READY) && (c_response == fetch_pkg::CACHE_RESP_WAIT);
    assign refill_write = (state == ST_REFILL) && mem_valid && !mem_error;

    // Answer to the command registered last cycle
    always_comb begin
        c_response = fetch_pkg::CACHE_RESP_IDLE;
        if (state == ST_REFILL) begin
            c_response = fetch_pkg::CACHE_RESP_WAIT;
        end else if (state == ST_READY) begin
            if (req_cmd == fetch_pkg::CACHE_CMD_FLUSH_ALL) begin
                c_response = fetch_pkg::CACHE_RESP_DONE;
            end else if (req_cmd == fetch_pkg::CACHE_CMD_EXECUTE) begin
                if (refill_err) begin
                    c_response = fetch_pkg::CACHE_RESP_ACCESSFAULT;
                end else if (req_addr[1:0] != 2'b00) begin
                    c_response = fetch_pkg::CACHE_RESP_MISSALIGNED;
                end else if (hit) begin
                    c_response = fetch_pkg::CACHE_RESP_DONE;
                end else begin
                    c_response = fetch_pkg::CACHE_RESP_WAIT;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            state      <= ST_INIT;
            init_idx   <= '0;
            refill_err <= 1'b0;
            req_cmd    <= fetch_pkg::CACHE_CMD_NONE;
            mem_req    <= 1'b0;
        end else begin
            req_cmd    <= c_cmd;
            refill_err <= 1'b0;
            case (state)
                ST_INIT: begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == IDX_W'(LINES - 1)) begin
                        state <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (start_refill) begin
                        state   <= ST_REFILL;
                        mem_req <= 1'b1;
                    end
                end
                default: begin
                    // Error flag makes the next repeat answer accessfault
                    if (mem_valid) begin
                        state      <= ST_READY;
                        mem_req    <= 1'b0;
                        refill_err <= mem_error;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        req_addr <= c_address;
        if (start_refill) begin
            mem_addr <= req_addr;
        end
    end

    // Valid bits, cleared line by line at start-up and all at once on flush
    always_ff @(posedge clk) begin
        if (state == ST_INIT) begin
            valid[init_idx] <= 1'b0;
        end else if (state == ST_READY && c_cmd == fetch_pkg::CACHE_CMD_FLUSH_ALL) begin
            valid <= '0;
        end else if (refill_write) begin
            valid[mem_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_write) begin
            tag_mem[mem_idx]  <= mem_addr[31:IDX_W+2];
            data_mem[mem_idx] <= mem_data;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module fetch_tb -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation ok"

/* tb.f */
+incdir+common
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/fetch_issue.sv
icache/icache.sv
verilog/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

/* verilog/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
    input  logic                clk,
    input  logic                reseted,
    input  logic [31:0]         csr_mtvec,
    input  logic                dbg_request,
    input  logic                dbg_set_pc,
    input  logic                dbg_exit_request,
    input  logic [31:0]         dbg_pc,
    output logic                dbg_mode,
    output logic                dbg_done,
    input  logic                irq_timer_en,
    input  logic                irq_exti_en,
    input  logic                irq_timer,
    input  logic                irq_exti,
    input  logic                e2f_ready,
    input  fetch_pkg::e2f_cmd_t e2f_cmd,
    input  logic [31:0]         e2f_exc_epc,
    input  logic [31:0]         e2f_branchtarget,
    output logic [31:0]         f2e_instr,
    output logic [31:0]         f2e_pc,
    output logic                f2e_exc_start,
    output fetch_pkg::cause_t   f2e_cause,
    output logic                mem_req,
    output logic [31:0]         mem_addr,
    input  logic                mem_valid,
    input  logic [31:0]         mem_data,
    input  logic                mem_error
);

    fetch_pkg::cache_cmd_t  c_cmd;
    fetch_pkg::cache_resp_t c_response;
    logic [31:0]            c_address;
    logic [31:0]            c_load_data;
    logic                   c_reset_done;
    logic [31:0]            pc;
    logic                   flushing;
    logic                   bubble;
    logic                   irq_taken_exti;
    logic                   irq_taken_timer;

    fetch_ctrl i_fetch_ctrl (
        .clk              (clk),
        .reseted          (reseted),
        .csr_mtvec        (csr_mtvec),
        .dbg_request      (dbg_request),
        .dbg_set_pc       (dbg_set_pc),
        .dbg_exit_request (dbg_exit_request),
        .dbg_pc           (dbg_pc),
        .irq_timer_en     (irq_timer_en),
        .irq_exti_en      (irq_exti_en),
        .irq_timer        (irq_timer),
        .irq_exti         (irq_exti),
        .e2f_ready        (e2f_ready),
        .e2f_cmd          (e2f_cmd),
        .e2f_exc_epc      (e2f_exc_epc),
        .e2f_branchtarget (e2f_branchtarget),
        .c_response       (c_response),
        .c_reset_done     (c_reset_done),
        .c_cmd            (c_cmd),
        .c_address        (c_address),
        .pc               (pc),
        .flushing         (flushing),
        .bubble           (bubble),
        .dbg_mode         (dbg_mode),
        .dbg_done         (dbg_done),
        .f2e_exc_start    (f2e_exc_start),
        .irq_taken_exti   (irq_taken_exti),
        .irq_taken_timer  (irq_taken_timer)
    );

    icache i_icache (
        .clk          (clk),
        .reseted      (reseted),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .mem_error    (mem_error),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr)
    );

    fetch_issue i_fetch_issue (
        .clk             (clk),
        .reseted         (reseted),
        .c_response      (c_response),
        .c_load_data     (c_load_data),
        .c_reset_done    (c_reset_done),
        .pc              (pc),
        .flushing        (flushing),
        .bubble          (bubble),
        .dbg_mode        (dbg_mode),
        .irq_taken_exti  (irq_taken_exti),
        .irq_taken_timer (irq_taken_timer),
        .f2e_instr       (f2e_instr),
        .f2e_pc          (f2e_pc),
        .f2e_cause       (f2e_cause)
    );

endmodule
